/* design/pq_pkg.sv */
package pq_pkg;

	// Entry fields
	localparam int RANK_W = 10;
	localparam int META_W = 10;

	// Register file at the front of the queue
	localparam int REG_DEPTH = 4;
	localparam int L2_REG_DEPTH = 2;

	// List storage, sentinels included
	localparam int MAX_NODES = 16;
	localparam int CAPACITY = MAX_NODES - 2 + REG_DEPTH;
	localparam int COUNT_W = 5;

	typedef logic [RANK_W-1:0] rank_t;
	typedef logic [META_W-1:0] meta_t;

	typedef struct packed {
		rank_t rank;
		meta_t meta;
	} entry_t;

	typedef logic [COUNT_W-1:0] count_t;

endpackage

/* design/list_pkg.sv */
package list_pkg;

	localparam int L2_NODES = 4;

	typedef logic [L2_NODES-1:0] node_ptr_t;

	// End marker in the head's left and the tail's right link
	localparam node_ptr_t NULL_PTR = '1;

	// Sentinel nodes
	localparam node_ptr_t HEAD_NODE = 4'd0;
	localparam node_ptr_t TAIL_NODE = 4'd1;
	localparam pq_pkg::rank_t HEAD_RANK = '1;
	localparam pq_pkg::rank_t TAIL_RANK = '0;

	typedef enum logic [3:0] {
		ST_INIT_SENT,
		ST_INIT_FREE,
		ST_IDLE,
		ST_SEARCH_READ,
		ST_SEARCH_STEP,
		ST_LINK_NEW,
		ST_LINK_NEIGH,
		ST_DEQ_READ,
		ST_DEQ_UNLINK
	} list_state_t;

endpackage

/* design/node_ram.sv */
module node_ram #(
	parameter type payload_t = logic [7:0]
) (
	input logic clk,
	input logic wr,
	input list_pkg::node_ptr_t waddr,
	input payload_t wdata,
	input list_pkg::node_ptr_t raddr,
	output payload_t rdata
);
	import list_pkg::*;

	payload_t mem [2**L2_NODES];

	// Registered read, old data on a same-address write
	always_ff @(posedge clk)
	begin
		if (wr)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

	// The list controller must always resolve its write address
	assert property (@(posedge clk) wr |-> !$isunknown(waddr));

endmodule

/* design/free_list.sv */
module free_list (
	input logic clk,
	input logic rst,
	input logic push,
	input list_pkg::node_ptr_t push_ptr,
	input logic pop,
	output list_pkg::node_ptr_t head_ptr,
	output logic empty
);
	import pq_pkg::*;
	import list_pkg::*;

	node_ptr_t slots [MAX_NODES];
	node_ptr_t rd_idx;
	node_ptr_t wr_idx;
	logic [L2_NODES:0] used;
	logic full;

	// Depth is a power of two, so the top bit marks full
	assign full = used[L2_NODES];
	assign empty = (used == '0);

	// Fall-through head
	assign head_ptr = slots[rd_idx];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_idx <= '0;
			wr_idx <= '0;
			used <= '0;
		end
		else
		begin
			if (push)
				wr_idx <= wr_idx + 1'b1;
			if (pop)
				rd_idx <= rd_idx + 1'b1;
			if (push && !pop)
				used <= used + 1'b1;
			else if (pop && !push)
				used <= used - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			slots[wr_idx] <= push_ptr;
	end

	assert property (@(posedge clk) disable iff (rst) pop |-> !empty);
	assert property (@(posedge clk) disable iff (rst) push |-> !full);

endmodule

/* design/sorted_list.sv */
module sorted_list (
	input logic clk,
	input logic rst,
	input logic list_insert,
	input pq_pkg::entry_t list_entry,
	input logic dequeue,
	output pq_pkg::entry_t list_out,
	output logic list_out_valid,
	output logic list_busy,
	output pq_pkg::count_t list_count,
	output logic list_full
);
	import pq_pkg::*;
	import list_pkg::*;

	list_state_t state;
	node_ptr_t init_ptr;
	node_ptr_t left;
	node_ptr_t right;
	node_ptr_t tail_left;
	node_ptr_t deq_node;
	entry_t new_entry;
	logic found;

	// Memory ports, one read address shared by all three
	node_ptr_t raddr;
	logic entry_wr;
	node_ptr_t entry_waddr;
	entry_t entry_wdata;
	entry_t entry_rdata;
	logic rptr_wr;
	node_ptr_t rptr_waddr;
	node_ptr_t rptr_wdata;
	node_ptr_t rptr_rdata;
	logic lptr_wr;
	node_ptr_t lptr_waddr;
	node_ptr_t lptr_wdata;
	node_ptr_t lptr_rdata;

	logic fl_push;
	logic fl_pop;
	node_ptr_t fl_push_ptr;
	node_ptr_t fl_head;
	logic fl_empty;

	node_ram #(.payload_t(entry_t)) u_entry_ram (
		.clk   (clk),
		.wr    (entry_wr),
		.waddr (entry_waddr),
		.wdata (entry_wdata),
		.raddr (raddr),
		.rdata (entry_rdata)
	);

	node_ram #(.payload_t(node_ptr_t)) u_rptr_ram (
		.clk   (clk),
		.wr    (rptr_wr),
		.waddr (rptr_waddr),
		.wdata (rptr_wdata),
		.raddr (raddr),
		.rdata (rptr_rdata)
	);

	node_ram #(.payload_t(node_ptr_t)) u_lptr_ram (
		.clk   (clk),
		.wr    (lptr_wr),
		.waddr (lptr_waddr),
		.wdata (lptr_wdata),
		.raddr (raddr),
		.rdata (lptr_rdata)
	);

	free_list u_free (
		.clk      (clk),
		.rst      (rst),
		.push     (fl_push),
		.push_ptr (fl_push_ptr),
		.pop      (fl_pop),
		.head_ptr (fl_head),
		.empty    (fl_empty)
	);

	assign list_busy = (state != ST_IDLE);
	assign list_full = fl_empty && (state != ST_INIT_SENT) && (state != ST_INIT_FREE);
	assign fl_push_ptr = (state == ST_DEQ_UNLINK) ? deq_node : init_ptr;

	// Stop in front of the first real node not ranked above the new one
	assign found = (right != HEAD_NODE) && (entry_rdata.rank <= new_entry.rank);

	always_comb
	begin
		entry_wr = 1'b0;
		rptr_wr = 1'b0;
		lptr_wr = 1'b0;
		entry_waddr = init_ptr;
		rptr_waddr = init_ptr;
		lptr_waddr = init_ptr;
		entry_wdata = '{rank: HEAD_RANK, meta: '1};
		rptr_wdata = TAIL_NODE;
		lptr_wdata = NULL_PTR;
		raddr = right;
		fl_push = 1'b0;
		fl_pop = 1'b0;
		case (state)
			ST_INIT_SENT:
			begin
				entry_wr = 1'b1;
				rptr_wr = 1'b1;
				lptr_wr = 1'b1;
				if (init_ptr == TAIL_NODE)
				begin
					entry_wdata = '{rank: TAIL_RANK, meta: '1};
					rptr_wdata = NULL_PTR;
					lptr_wdata = HEAD_NODE;
				end
			end
			ST_INIT_FREE:
				fl_push = 1'b1;
			ST_SEARCH_STEP:
				// Follow the link straight away, one node per cycle
				if (!found)
					raddr = rptr_rdata;
			ST_LINK_NEW:
			begin
				entry_wr = 1'b1;
				rptr_wr = 1'b1;
				lptr_wr = 1'b1;
				entry_waddr = fl_head;
				rptr_waddr = fl_head;
				lptr_waddr = fl_head;
				entry_wdata = new_entry;
				rptr_wdata = right;
				lptr_wdata = left;
			end
			ST_LINK_NEIGH:
			begin
				rptr_wr = 1'b1;
				lptr_wr = 1'b1;
				rptr_waddr = left;
				lptr_waddr = right;
				rptr_wdata = fl_head;
				lptr_wdata = fl_head;
				fl_pop = 1'b1;
			end
			ST_DEQ_READ:
				raddr = deq_node;
			ST_DEQ_UNLINK:
			begin
				// Bridge the removed node's left neighbour to the tail
				rptr_wr = 1'b1;
				lptr_wr = 1'b1;
				rptr_waddr = lptr_rdata;
				lptr_waddr = TAIL_NODE;
				rptr_wdata = TAIL_NODE;
				lptr_wdata = lptr_rdata;
				fl_push = 1'b1;
			end
			default:
				raddr = right;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_INIT_SENT;
			init_ptr <= HEAD_NODE;
			tail_left <= HEAD_NODE;
			list_count <= '0;
			list_out_valid <= 1'b0;
		end
		else
		begin
			list_out_valid <= 1'b0;
			case (state)
				ST_INIT_SENT:
				begin
					init_ptr <= init_ptr + 1'b1;
					if (init_ptr == TAIL_NODE)
						state <= ST_INIT_FREE;
				end
				ST_INIT_FREE:
				begin
					init_ptr <= init_ptr + 1'b1;
					if (init_ptr == node_ptr_t'(MAX_NODES - 1))
						state <= ST_IDLE;
				end
				ST_IDLE:
					if (list_insert)
					begin
						new_entry <= list_entry;
						right <= HEAD_NODE;
						list_count <= list_count + 1'b1;
						state <= ST_SEARCH_READ;
					end
					else if (dequeue)
					begin
						deq_node <= tail_left;
						state <= ST_DEQ_READ;
					end
				ST_SEARCH_READ:
					state <= ST_SEARCH_STEP;
				ST_SEARCH_STEP:
					if (found)
						state <= ST_LINK_NEW;
					else
					begin
						left <= right;
						right <= rptr_rdata;
					end
				ST_LINK_NEW:
					state <= ST_LINK_NEIGH;
				ST_LINK_NEIGH:
				begin
					if (right == TAIL_NODE)
						tail_left <= fl_head;
					state <= ST_IDLE;
				end
				ST_DEQ_READ:
					state <= ST_DEQ_UNLINK;
				ST_DEQ_UNLINK:
				begin
					list_out <= entry_rdata;
					list_out_valid <= 1'b1;
					list_count <= list_count - 1'b1;
					tail_left <= lptr_rdata;
					state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst) list_insert |-> !list_full);
	assert property (@(posedge clk) disable iff (rst) dequeue |-> list_count != '0);

endmodule

/* design/pifo_reg.sv */
module pifo_reg (
	input logic clk,
	input logic rst,
	input logic reg_insert,
	input pq_pkg::entry_t reg_entry,
	input logic remove,
	output pq_pkg::entry_t entry_out,
	output logic valid_out,
	output pq_pkg::entry_t reg_max,
	output logic [pq_pkg::L2_REG_DEPTH:0] reg_count,
	output logic reg_full,
	output logic reg_empty
);
	import pq_pkg::*;

	typedef logic [L2_REG_DEPTH-1:0] idx_t;

	entry_t slot [REG_DEPTH];
	logic [REG_DEPTH-1:0] valid;
	idx_t min_idx;
	idx_t max_idx;
	idx_t free_idx;
	idx_t ins_idx;
	logic have_min;
	logic have_max;
	logic take;

	// First minimum and last maximum, so they differ once two entries are held
	always_comb
	begin
		have_min = 1'b0;
		have_max = 1'b0;
		min_idx = '0;
		max_idx = '0;
		free_idx = '0;
		for (int i = 0; i < REG_DEPTH; i++)
		begin
			if (valid[i] && (!have_min || slot[i].rank < slot[min_idx].rank))
			begin
				min_idx = idx_t'(i);
				have_min = 1'b1;
			end
			if (valid[i] && (!have_max || slot[i].rank >= slot[max_idx].rank))
			begin
				max_idx = idx_t'(i);
				have_max = 1'b1;
			end
		end
		for (int i = REG_DEPTH - 1; i >= 0; i--)
			if (!valid[i])
				free_idx = idx_t'(i);
	end

	always_comb
	begin
		reg_count = '0;
		for (int i = 0; i < REG_DEPTH; i++)
			reg_count = reg_count + {{L2_REG_DEPTH{1'b0}}, valid[i]};
	end

	assign reg_full = &valid;
	assign reg_empty = ~|valid;
	assign reg_max = slot[max_idx];
	assign take = remove && !reg_empty;

	// When full the evicted maximum has already been sent to the list
	assign ins_idx = reg_full ? max_idx : free_idx;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid <= '0;
			valid_out <= 1'b0;
		end
		else
		begin
			valid_out <= take;
			if (take)
				valid[min_idx] <= 1'b0;
			if (reg_insert)
				valid[ins_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
			entry_out <= slot[min_idx];
		if (reg_insert)
			slot[ins_idx] <= reg_entry;
	end

endmodule

/* design/insert_router.sv */
module insert_router (
	input logic clk,
	input logic rst,
	input logic insert,
	input pq_pkg::entry_t entry_in,
	input pq_pkg::entry_t reg_max,
	input logic [pq_pkg::L2_REG_DEPTH:0] reg_count,
	input logic reg_full,
	input logic reg_empty,
	output logic reg_insert,
	output pq_pkg::entry_t reg_entry,
	input pq_pkg::entry_t list_out,
	input logic list_out_valid,
	input logic list_busy,
	input pq_pkg::count_t list_count,
	input logic list_full,
	output logic list_insert,
	output pq_pkg::entry_t list_entry,
	output logic dequeue,
	output logic busy,
	output pq_pkg::count_t num_entries
);
	import pq_pkg::*;

	logic list_empty;
	logic list_pending;
	logic accept;
	logic below_max;
	logic to_reg;
	logic evict;

	assign list_empty = (list_count == '0);

	// List work in flight, including strobes not yet seen by the list
	assign list_pending = list_busy || list_insert || dequeue || list_out_valid;
	assign busy = list_pending || (reg_empty && !list_empty);

	assign accept = insert && !busy && !list_full;
	assign below_max = (entry_in.rank < reg_max.rank);
	assign to_reg = (reg_empty || !reg_full) && (below_max || list_empty);
	assign evict = reg_full && below_max;

	// Refills and accepted inserts never meet, busy keeps them apart
	assign reg_insert = list_out_valid || (accept && (to_reg || evict));
	assign reg_entry = list_out_valid ? list_out : entry_in;

	assign num_entries = count_t'(reg_count) + list_count + count_t'(list_insert)
		+ count_t'(list_out_valid);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			list_insert <= 1'b0;
			dequeue <= 1'b0;
		end
		else
		begin
			list_insert <= accept && !to_reg;
			dequeue <= !reg_full && !list_empty && !list_pending && !insert;
		end
	end

	// Evicted maximum or the new entry itself
	always_ff @(posedge clk)
	begin
		if (accept)
			list_entry <= evict ? reg_max : entry_in;
	end

	assert property (@(posedge clk) disable iff (rst) num_entries <= CAPACITY);

endmodule

/* design/rank_queue.sv */
module rank_queue (
	input logic clk,
	input logic rst,
	input logic insert,
	input logic remove,
	input pq_pkg::entry_t entry_in,
	output pq_pkg::entry_t entry_out,
	output logic valid_out,
	output pq_pkg::count_t num_entries,
	output logic busy,
	output logic full
);
	import pq_pkg::*;

	entry_t reg_entry;
	entry_t reg_max;
	entry_t list_entry;
	entry_t list_out;
	logic reg_insert;
	logic reg_full;
	logic reg_empty;
	logic [L2_REG_DEPTH:0] reg_count;
	logic list_insert;
	logic dequeue;
	logic list_out_valid;
	logic list_busy;
	count_t list_count;

	insert_router u_router (
		.clk            (clk),
		.rst            (rst),
		.insert         (insert),
		.entry_in       (entry_in),
		.reg_max        (reg_max),
		.reg_count      (reg_count),
		.reg_full       (reg_full),
		.reg_empty      (reg_empty),
		.reg_insert     (reg_insert),
		.reg_entry      (reg_entry),
		.list_out       (list_out),
		.list_out_valid (list_out_valid),
		.list_busy      (list_busy),
		.list_count     (list_count),
		.list_full      (full),
		.list_insert    (list_insert),
		.list_entry     (list_entry),
		.dequeue        (dequeue),
		.busy           (busy),
		.num_entries    (num_entries)
	);

	sorted_list u_list (
		.clk            (clk),
		.rst            (rst),
		.list_insert    (list_insert),
		.list_entry     (list_entry),
		.dequeue        (dequeue),
		.list_out       (list_out),
		.list_out_valid (list_out_valid),
		.list_busy      (list_busy),
		.list_count     (list_count),
		.list_full      (full)
	);

	pifo_reg u_reg (
		.clk        (clk),
		.rst        (rst),
		.reg_insert (reg_insert),
		.reg_entry  (reg_entry),
		.remove     (remove),
		.entry_out  (entry_out),
		.valid_out  (valid_out),
		.reg_max    (reg_max),
		.reg_count  (reg_count),
		.reg_full   (reg_full),
		.reg_empty  (reg_empty)
	);

endmodule

/* test/tb_rank_queue.sv */
module tb_rank_queue;
	timeunit 1ns;
	timeprecision 1ps;

	import pq_pkg::*;

	// Five tests, about twenty operations each, at most forty cycles per operation
	localparam int CYCLE_LIMIT = 5 * 20 * 40;

	logic clk = 1'b0;
	logic rst;
	logic insert;
	logic remove;
	entry_t entry_in;
	entry_t entry_out;
	logic valid_out;
	count_t num_entries;
	logic busy;
	logic full;

	logic [31:0] lfsr_state = 32'd93619;
	entry_t model_q[$];
	int error_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycle_count = 0;

	rank_queue UUT (
		.clk         (clk),
		.rst         (rst),
		.insert      (insert),
		.remove      (remove),
		.entry_in    (entry_in),
		.entry_out   (entry_out),
		.valid_out   (valid_out),
		.num_entries (num_entries),
		.busy        (busy),
		.full        (full)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	function automatic logic rank_taken(input rank_t r);
		foreach (model_q[i])
			if (model_q[i].rank == r)
				return 1'b1;
		return 1'b0;
	endfunction

	// Ranks stay distinct so the removal order is fully defined
	function automatic entry_t random_entry();
		entry_t e;
		e.rank = rank_t'(random_bits(RANK_W));
		while (rank_taken(e.rank))
			e.rank = rank_t'(random_bits(RANK_W));
		e.meta = meta_t'(random_bits(META_W));
		return e;
	endfunction

	// Model kept in ascending rank order
	function automatic void model_insert(input entry_t e);
		int pos;
		pos = 0;
		while (pos < model_q.size() && model_q[pos].rank < e.rank)
			pos++;
		model_q.insert(pos, e);
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			error_count++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("Error: %s", msg);
		error_count++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before)
		begin
			tests_passed++;
			$display("%s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (busy)
			@(negedge clk);
	endtask

	// Strobe insert in a cycle where busy is low, retry if the list woke up meanwhile
	task automatic push_entry(input entry_t e, output logic accepted);
		logic done;
		accepted = 1'b0;
		done = 1'b0;
		while (!done)
		begin
			wait_idle();
			if (full)
				done = 1'b1;
			else
			begin
				@(posedge clk);
				insert <= 1'b1;
				entry_in <= e;
				@(negedge clk);
				if (!busy && !full)
				begin
					accepted = 1'b1;
					done = 1'b1;
				end
				@(posedge clk);
				insert <= 1'b0;
			end
		end
		if (accepted)
			model_insert(e);
		@(negedge clk);
	endtask

	task automatic pop_entry();
		entry_t expected;
		logic expect_valid;
		wait_idle();
		@(posedge clk);
		remove <= 1'b1;
		@(negedge clk);
		check_value("valid_out", valid_out, 1'b0);
		@(posedge clk);
		remove <= 1'b0;
		@(negedge clk);
		expect_valid = (model_q.size() != 0);
		check_value("valid_out", valid_out, expect_valid);
		if (expect_valid)
		begin
			expected = model_q.pop_front();
			check_value("entry_out.rank", entry_out.rank, expected.rank);
			check_value("entry_out.meta", entry_out.meta, expected.meta);
		end
	endtask

	task automatic fill_random(input int n);
		logic acc;
		for (int i = 0; i < n; i++)
		begin
			push_entry(random_entry(), acc);
			if (!acc)
				report_error("an insert was refused while the queue had room");
		end
	endtask

	task automatic drain_all(input int n);
		for (int i = 0; i < n; i++)
		begin
			pop_entry();
			check_value("num_entries", num_entries, model_q.size());
		end
	endtask

	initial
	begin
		int errors_before;
		int waited;
		logic acc;

		rst = 1'b1;
		insert = 1'b0;
		remove = 1'b0;
		entry_in = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// Test 1, reset state and remove on empty
		errors_before = error_count;
		waited = 0;
		@(negedge clk);
		while (busy && waited < 40)
		begin
			@(negedge clk);
			waited++;
		end
		if (busy)
			report_error("busy stayed high for 40 cycles after reset");
		check_value("num_entries", num_entries, 0);
		check_value("full", full, 1'b0);
		check_value("valid_out", valid_out, 1'b0);
		pop_entry();
		finish_test("test 1 reset", errors_before);

		// Test 2, register file only
		errors_before = error_count;
		fill_random(REG_DEPTH);
		check_value("num_entries", num_entries, REG_DEPTH);
		drain_all(REG_DEPTH);
		finish_test("test 2 register file", errors_before);

		// Test 3, eviction into the list and refill
		errors_before = error_count;
		fill_random(12);
		wait_idle();
		check_value("num_entries", num_entries, 12);
		drain_all(12);
		finish_test("test 3 spill and refill", errors_before);

		// Test 4, capacity
		errors_before = error_count;
		fill_random(CAPACITY);
		wait_idle();
		check_value("full", full, 1'b1);
		check_value("num_entries", num_entries, CAPACITY);
		@(posedge clk);
		insert <= 1'b1;
		entry_in <= random_entry();
		@(posedge clk);
		insert <= 1'b0;
		wait_idle();
		check_value("num_entries", num_entries, CAPACITY);
		drain_all(CAPACITY);
		wait_idle();
		check_value("full", full, 1'b0);
		finish_test("test 4 capacity", errors_before);

		// Test 5, random mix of inserts and removes
		errors_before = error_count;
		for (int op = 0; op < 60; op++)
		begin
			if (random_bits(1) == 1)
			begin
				push_entry(random_entry(), acc);
				if (!acc && model_q.size() != CAPACITY)
					report_error("an insert was refused while the queue had room");
			end
			else
				pop_entry();
			check_value("num_entries", num_entries, model_q.size());
		end
		finish_test("test 5 random mix", errors_before);

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* all.f */
design/pq_pkg.sv
design/list_pkg.sv
design/node_ram.sv
design/free_list.sv
design/sorted_list.sv
design/pifo_reg.sv
design/insert_router.sv
design/rank_queue.sv
test/tb_rank_queue.sv
